// ==== run.sh ====
#!/usr/bin/env bash
# Build the tile testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tile_tb -f tb.f --Mdir obj_dir -o tile_sim

./obj_dir/tile_sim | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== sim/tile_chk.sv ====
/*
  Concurrent assertions on the tile handshakes and command routing.
  Attached to every mem_tile by the bind at the end of this file.
*/
`timescale 1ns/1ps

module tile_chk
(
  input logic                clk_i,
  input logic                rst_i,
  input logic                rst_int_i,
  input logic [3:0]          tgt_v_i,
  input tile_pkg::mem_resp_s resp_i,
  input logic                resp_v_i,
  input logic                resp_ready_i,
  input logic                cmd_ready_i
);

  // At most one target takes a command
  a_tgt_onehot: assert property (@(posedge clk_i) disable iff (rst_i || rst_int_i)
    $onehot0(tgt_v_i))
    else $error("more than one target valid in the same cycle");

  // Response holds while back-pressured
  a_resp_hold: assert property (@(posedge clk_i) disable iff (rst_i || rst_int_i)
    resp_v_i && !resp_ready_i |=> resp_v_i && $stable(resp_i))
    else $error("response changed or dropped before it was accepted");

  a_cmd_stall: assert property (@(posedge clk_i) disable iff (rst_i || rst_int_i)
    resp_v_i |-> !cmd_ready_i)
    else $error("command ready while a response is pending");

endmodule

bind mem_tile tile_chk chk_i
(
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .rst_int_i    (rst_r),
  .tgt_v_i      (tgt_v),
  .resp_i       (resp_o),
  .resp_v_i     (resp_v_o),
  .resp_ready_i (resp_ready_i),
  .cmd_ready_i  (cmd_ready_o)
);

// ==== sim/tile_tb.sv ====
/*
  Testbench for the memory-side tile. Sends directed and random commands,
  predicts every response from a model of the targets and compares the
  response stream under random back-pressure.
*/
`timescale 1ns/1ps

module tile_tb;
  import tile_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int MEM_WORDS  = 64;
  localparam int N_POOL     = 12;
  localparam int N_RAND     = 150;
  // Directed commands, rounded up
  localparam int N_DIRECTED = 40;
  localparam int N_CMDS     = N_POOL + N_RAND + N_DIRECTED;
  localparam logic [31:0] SEED = 32'hddea_b00a;

  logic      clk_i = 1'b0;
  logic      rst_i;
  mem_cmd_s  cmd_i;
  logic      cmd_v_i;
  logic      cmd_ready_o;
  mem_resp_s resp_o;
  logic      resp_v_o;
  logic      resp_ready_i;
  cfg_s      cfg_o;
  logic      timer_irq_o;
  logic      software_irq_o;
  logic      external_irq_o;

  // Model state
  logic [DATA_W-1:0] mem_m [int];
  logic              freeze_m;
  logic [7:0]        core_id_m;
  logic              msip_m;
  logic              meip_m;
  logic [DATA_W-1:0] mtimecmp_m;

  mem_resp_s         exp_q [$];
  mem_resp_s         exp_r;
  logic [ADDR_W-1:0] pool [N_POOL];
  int                errors     = 0;
  int                sent       = 0;
  int                resp_count = 0;

  mem_tile #(.MEM_WORDS_P(MEM_WORDS)) dut_i
  (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .cmd_i          (cmd_i),
    .cmd_v_i        (cmd_v_i),
    .cmd_ready_o    (cmd_ready_o),
    .resp_o         (resp_o),
    .resp_v_o       (resp_v_o),
    .resp_ready_i   (resp_ready_i),
    .cfg_o          (cfg_o),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o),
    .external_irq_o (external_irq_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic tgt_e target_of(input logic [ADDR_W-1:0] addr);
    if (addr >= MEM_BASE || addr[19:16] == 4'd0)
      return e_tgt_mem;
    if (addr[19:16] == 4'd2)
      return e_tgt_cfg;
    if (addr[19:16] == 4'd1)
      return e_tgt_clint;
    return e_tgt_loop;
  endfunction

  function automatic int word_of(input logic [ADDR_W-1:0] addr);
    return int'((addr >> 3) % MEM_WORDS);
  endfunction

  function automatic logic [ADDR_W-1:0] cfg_addr(input logic [7:0] ofs);
    return {16'h0002, 8'h00, ofs};
  endfunction

  function automatic logic [ADDR_W-1:0] clint_addr(input logic [15:0] ofs);
    return {16'h0001, ofs};
  endfunction

  // Local address in an unmapped device window
  function automatic logic [ADDR_W-1:0] loop_addr(input logic [3:0] dev);
    logic [ADDR_W-1:0] a;
    a = {1'b0, 11'($urandom), dev, 16'($urandom)};
    return a;
  endfunction

  // Expected response from the model state before the command
  function automatic mem_resp_s predict(input mem_cmd_s c);
    logic [DATA_W-1:0] d;
    d = '0;
    if (c.op == e_op_rd)
    begin
      case (target_of(c.addr))
        e_tgt_mem:
          d = mem_m[word_of(c.addr)];
        e_tgt_cfg:
          if (c.addr[7:0] == CFG_FREEZE_OFS)
            d = DATA_W'(freeze_m);
          else if (c.addr[7:0] == CFG_CORE_ID_OFS)
            d = DATA_W'(core_id_m);
        e_tgt_clint:
          if (c.addr[15:0] == CLINT_MSIP_OFS)
            d = DATA_W'(msip_m);
          else if (c.addr[15:0] == CLINT_MEIP_OFS)
            d = DATA_W'(meip_m);
          else if (c.addr[15:0] == CLINT_MTIMECMP_OFS)
            d = mtimecmp_m;
        default:
          d = '0;
      endcase
    end
    return '{op: c.op, addr: c.addr, data: d};
  endfunction

  function automatic void update_model(input mem_cmd_s c);
    if (c.op == e_op_wr)
    begin
      case (target_of(c.addr))
        e_tgt_mem:
          mem_m[word_of(c.addr)] = c.data;
        e_tgt_cfg:
          if (c.addr[7:0] == CFG_FREEZE_OFS)
            freeze_m = c.data[0];
          else if (c.addr[7:0] == CFG_CORE_ID_OFS)
            core_id_m = c.data[7:0];
        e_tgt_clint:
          if (c.addr[15:0] == CLINT_MSIP_OFS)
            msip_m = c.data[0];
          else if (c.addr[15:0] == CLINT_MEIP_OFS)
            meip_m = c.data[0];
          else if (c.addr[15:0] == CLINT_MTIMECMP_OFS)
            mtimecmp_m = c.data;
        default:
          ;
      endcase
    end
  endfunction

  // Starts and ends 1 ns after a rising edge
  task automatic issue(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data);
    mem_cmd_s c;
    c = '{op: op, addr: addr, data: data};
    exp_q.push_back(predict(c));
    update_model(c);
    cmd_i   = c;
    cmd_v_i = 1'b1;
    @(posedge clk_i);
    while (!cmd_ready_o)
      @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
    sent++;
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic check_val(input string what, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] want);
    if (got !== want)
    begin
      errors++;
      $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  // Roughly one cycle in three without ready
  always @(posedge clk_i)
  begin
    #1;
    resp_ready_i = (($urandom % 3) != 0);
  end

  always @(posedge clk_i)
  begin
    if (!rst_i && resp_v_o === 1'b1 && resp_ready_i === 1'b1)
    begin
      resp_count++;
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("A response came out at %0t with no command outstanding", $time);
      end
      else
      begin
        exp_r = exp_q.pop_front();
        if (resp_o !== exp_r)
        begin
          errors++;
          $display("ERROR %0t: got op %0d addr %h data %h, expected op %0d addr %h data %h",
                   $time, resp_o.op, resp_o.addr, resp_o.data,
                   exp_r.op, exp_r.addr, exp_r.data);
        end
      end
    end
  end

  initial
  begin
    #(CLK_PERIOD * (200 * N_CMDS + 50));
    $display("Watchdog expired: the run did not finish in %0d cycles", 200 * N_CMDS + 50);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    int k;
    int p;
    logic [7:0] id;
    void'($urandom(SEED));
    rst_i        = 1'b1;
    cmd_i        = '0;
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b0;
    freeze_m     = 1'b1;
    core_id_m    = 8'd0;
    msip_m       = 1'b0;
    meip_m       = 1'b0;
    mtimecmp_m   = '1;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // Internal reset drops one edge later
    repeat (2) @(posedge clk_i);
    #1;
    check_val("resp_v_o", resp_v_o, 0);
    check_val("cmd_ready_o", cmd_ready_o, 1);
    check_val("timer_irq_o", timer_irq_o, 0);
    check_val("software_irq_o", software_irq_o, 0);
    check_val("external_irq_o", external_irq_o, 0);
    check_val("cfg_o.freeze", cfg_o.freeze, 1);

    // Fill the address pool before any read
    for (int i = 0; i < N_POOL; i++)
    begin
      pool[i] = MEM_BASE | ADDR_W'($urandom);
      issue(e_op_wr, pool[i], {$urandom, $urandom});
    end

    // Nonzero so it differs from the reset value
    id = 8'(1 + $urandom % 255);
    issue(e_op_wr, cfg_addr(CFG_FREEZE_OFS), '0);
    drain();
    check_val("cfg_o.freeze", cfg_o.freeze, freeze_m);
    issue(e_op_wr, cfg_addr(CFG_CORE_ID_OFS), DATA_W'(id));
    drain();
    check_val("cfg_o.core_id", cfg_o.core_id, core_id_m);
    issue(e_op_rd, cfg_addr(CFG_FREEZE_OFS), '0);
    issue(e_op_rd, cfg_addr(CFG_CORE_ID_OFS), '0);

    issue(e_op_wr, clint_addr(CLINT_MSIP_OFS), 1);
    drain();
    check_val("software_irq_o", software_irq_o, 1);
    issue(e_op_wr, clint_addr(CLINT_MSIP_OFS), 0);
    drain();
    check_val("software_irq_o", software_irq_o, 0);
    issue(e_op_wr, clint_addr(CLINT_MEIP_OFS), 1);
    drain();
    check_val("external_irq_o", external_irq_o, 1);
    issue(e_op_wr, clint_addr(CLINT_MEIP_OFS), 0);
    drain();
    check_val("external_irq_o", external_irq_o, 0);

    // mtime starts at zero, so a zero compare fires at once
    issue(e_op_wr, clint_addr(CLINT_MTIMECMP_OFS), '0);
    drain();
    check_val("timer_irq_o", timer_irq_o, 1);
    issue(e_op_rd, clint_addr(CLINT_MTIMECMP_OFS), '0);
    issue(e_op_wr, clint_addr(CLINT_MTIMECMP_OFS), '1);
    drain();
    check_val("timer_irq_o", timer_irq_o, 0);
    issue(e_op_rd, clint_addr(CLINT_MTIMECMP_OFS), '0);

    for (int d = 3; d < 16; d++)
      issue(mem_op_e'(d % 2), loop_addr(4'(d)), {$urandom, $urandom});

    for (int n = 0; n < N_RAND; n++)
    begin
      k = $urandom % 4;
      p = $urandom % N_POOL;
      case (k)
        0:       issue(e_op_wr, pool[p], {$urandom, $urandom});
        1:       issue(e_op_rd, pool[p], '0);
        2:       issue(mem_op_e'($urandom % 2), loop_addr(4'(3 + $urandom % 13)), '1);
        default: issue(e_op_rd, cfg_addr(CFG_CORE_ID_OFS), '0);
      endcase
    end

    drain();
    // Idle cycles catch a repeated response
    repeat (4) @(posedge clk_i);
    if (resp_count != sent)
    begin
      errors++;
      $display("Sent %0d commands but got %0d responses", sent, resp_count);
    end
    $display("Run done: %0d errors, %0d commands, %0d responses", errors, sent, resp_count);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/tile_pkg.sv
verilog/cmd_dispatch.sv
verilog/local_mem.sv
verilog/cfg_regs.sv
verilog/clint_slice.sv
verilog/resp_collect.sv
verilog/mem_tile.sv
sim/tile_chk.sv
sim/tile_tb.sv

// ==== verilog/cfg_regs.sv ====
/*
  Configuration register block. Holds freeze and core_id, answers reads
  and writes from the dispatcher and drives them onto cfg_o.
*/
`timescale 1ns/1ps

module cfg_regs
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  tile_pkg::mem_cmd_s  cmd_i,
  input  logic                cmd_v_i,
  output logic                cmd_ready_o,
  output tile_pkg::mem_resp_s resp_o,
  output logic                resp_v_o,
  input  logic                resp_yumi_i,
  output tile_pkg::cfg_s      cfg_o
);
  import tile_pkg::*;

  cfg_s              cfg_r;
  mem_resp_s         resp_r;
  logic              resp_v_r;
  logic [7:0]        ofs;
  logic [DATA_W-1:0] rdata;
  logic              is_wr;

  assign ofs   = cmd_i.addr[7:0];
  assign is_wr = (cmd_i.op == e_op_wr);

  always_comb
  begin
    case (ofs)
      CFG_FREEZE_OFS:  rdata = DATA_W'(cfg_r.freeze);
      CFG_CORE_ID_OFS: rdata = DATA_W'(cfg_r.core_id);
      default:         rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cfg_r    <= '{freeze: 1'b1, core_id: 8'd0};
      resp_v_r <= 1'b0;
    end
    else
    begin
      if (cmd_v_i && is_wr && ofs == CFG_FREEZE_OFS)
        cfg_r.freeze <= cmd_i.data[0];
      if (cmd_v_i && is_wr && ofs == CFG_CORE_ID_OFS)
        cfg_r.core_id <= cmd_i.data[7:0];
      if (cmd_v_i)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      resp_r <= '{op: cmd_i.op, addr: cmd_i.addr, data: is_wr ? '0 : rdata};
    end
  end

  assign cmd_ready_o = ~resp_v_r;
  assign resp_o      = resp_r;
  assign resp_v_o    = resp_v_r;
  assign cfg_o       = cfg_r;

endmodule

// ==== verilog/clint_slice.sv ====
/*
  Interrupt and timer slice. mtime runs freely and is compared with
  mtimecmp for the timer interrupt; msip and meip drive the software and
  external interrupts. All four registers are readable and writable.
*/
`timescale 1ns/1ps

module clint_slice
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  tile_pkg::mem_cmd_s  cmd_i,
  input  logic                cmd_v_i,
  output logic                cmd_ready_o,
  output tile_pkg::mem_resp_s resp_o,
  output logic                resp_v_o,
  input  logic                resp_yumi_i,
  output logic                timer_irq_o,
  output logic                software_irq_o,
  output logic                external_irq_o
);
  import tile_pkg::*;

  logic [DATA_W-1:0] mtime_r;
  logic [DATA_W-1:0] mtimecmp_r;
  logic              msip_r;
  logic              meip_r;
  mem_resp_s         resp_r;
  logic              resp_v_r;
  logic [15:0]       ofs;
  logic              wr_v;
  logic [DATA_W-1:0] rdata;

  assign ofs  = cmd_i.addr[15:0];
  assign wr_v = cmd_v_i && (cmd_i.op == e_op_wr);

  always_comb
  begin
    case (ofs)
      CLINT_MSIP_OFS:     rdata = DATA_W'(msip_r);
      CLINT_MEIP_OFS:     rdata = DATA_W'(meip_r);
      CLINT_MTIMECMP_OFS: rdata = mtimecmp_r;
      CLINT_MTIME_OFS:    rdata = mtime_r;
      default:            rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
      meip_r     <= 1'b0;
      resp_v_r   <= 1'b0;
    end
    else
    begin
      // A write to mtime takes over from the increment
      if (wr_v && ofs == CLINT_MTIME_OFS)
        mtime_r <= cmd_i.data;
      else
        mtime_r <= mtime_r + 1'b1;
      if (wr_v && ofs == CLINT_MTIMECMP_OFS)
        mtimecmp_r <= cmd_i.data;
      if (wr_v && ofs == CLINT_MSIP_OFS)
        msip_r <= cmd_i.data[0];
      if (wr_v && ofs == CLINT_MEIP_OFS)
        meip_r <= cmd_i.data[0];
      if (cmd_v_i)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      resp_r <= '{op: cmd_i.op, addr: cmd_i.addr, data: (cmd_i.op == e_op_wr) ? '0 : rdata};
    end
  end

  assign cmd_ready_o    = ~resp_v_r;
  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;
  assign external_irq_o = meip_r;

endmodule

// ==== verilog/cmd_dispatch.sv ====
/*
  Address decode for incoming commands. Picks one of four targets and
  raises its valid only when every target is ready, so a command is
  never consumed by one target while the tile stalls it.
*/
`timescale 1ns/1ps

module cmd_dispatch
(
  input  tile_pkg::mem_cmd_s cmd_i,
  input  logic               cmd_v_i,
  input  logic [3:0]         tgt_ready_i,
  output logic               cmd_ready_o,
  output tile_pkg::mem_cmd_s tgt_cmd_o,
  output logic [3:0]         tgt_v_o
);
  import tile_pkg::*;

  logic local_cmd;
  dev_e dev;
  tgt_e tgt_sel;

  assign local_cmd = (cmd_i.addr < MEM_BASE);
  assign dev       = dev_e'(cmd_i.addr[DEV_LSB +: 4]);

  always_comb
  begin
    if (!local_cmd)
    begin
      tgt_sel = e_tgt_mem;
    end
    else
    begin
      case (dev)
        e_dev_mem:   tgt_sel = e_tgt_mem;
        e_dev_cfg:   tgt_sel = e_tgt_cfg;
        e_dev_clint: tgt_sel = e_tgt_clint;
        default:     tgt_sel = e_tgt_loop;
      endcase
    end
  end

  assign cmd_ready_o = &tgt_ready_i;

  // Gate with the combined ready
  assign tgt_v_o   = (cmd_v_i && cmd_ready_o) ? (4'b0001 << tgt_sel) : 4'b0000;
  assign tgt_cmd_o = cmd_i;

endmodule

// ==== verilog/local_mem.sv ====
/*
  Word-addressed storage standing in for the cached memory path.
  Depth is MEM_WORDS_P 64-bit words; the word index wraps at the depth.
*/
`timescale 1ns/1ps

module local_mem
#(
  parameter int MEM_WORDS_P = 64
)
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  tile_pkg::mem_cmd_s  cmd_i,
  input  logic                cmd_v_i,
  output logic                cmd_ready_o,
  output tile_pkg::mem_resp_s resp_o,
  output logic                resp_v_o,
  input  logic                resp_yumi_i
);
  import tile_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS_P);

  logic [DATA_W-1:0] mem_r [MEM_WORDS_P];
  logic [IDX_W-1:0]  word_idx;
  logic              is_wr;
  mem_resp_s         resp_r;
  logic              resp_v_r;

  // Skip the byte offset, then wrap at the depth
  assign word_idx = IDX_W'(cmd_i.addr[ADDR_W-1:3] % MEM_WORDS_P);
  assign is_wr    = (cmd_i.op == e_op_wr);

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i && is_wr)
      mem_r[word_idx] <= cmd_i.data;
    if (cmd_v_i)
      resp_r <= '{op: cmd_i.op, addr: cmd_i.addr, data: is_wr ? '0 : mem_r[word_idx]};
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_v_r <= 1'b0;
    else if (cmd_v_i)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  assign cmd_ready_o = ~resp_v_r;
  assign resp_o      = resp_r;
  assign resp_v_o    = resp_v_r;

endmodule

// ==== verilog/mem_tile.sv ====
/*
  Top level of the memory-side tile. Registers reset, fans commands out to
  memory, cfg, clint and loopback, and merges their responses into one
  valid/ready stream.
*/
`timescale 1ns/1ps

module mem_tile
#(
  parameter int MEM_WORDS_P = 64
)
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  tile_pkg::mem_cmd_s  cmd_i,
  input  logic                cmd_v_i,
  output logic                cmd_ready_o,
  output tile_pkg::mem_resp_s resp_o,
  output logic                resp_v_o,
  input  logic                resp_ready_i,
  output tile_pkg::cfg_s      cfg_o,
  output logic                timer_irq_o,
  output logic                software_irq_o,
  output logic                external_irq_o
);
  import tile_pkg::*;

  logic            rst_r;
  mem_cmd_s        tgt_cmd;
  logic [3:0]      tgt_v;
  logic [3:0]      tgt_ready;
  mem_resp_s [2:0] tgt_resp;
  logic [2:0]      tgt_resp_v;
  logic [2:0]      tgt_yumi;

  // Internal reset lags the pin by one cycle
  always_ff @(posedge clk_i)
  begin
    rst_r <= rst_i;
  end

  cmd_dispatch dispatch_i
  (
    .cmd_i       (cmd_i),
    .cmd_v_i     (cmd_v_i),
    .tgt_ready_i (tgt_ready),
    .cmd_ready_o (cmd_ready_o),
    .tgt_cmd_o   (tgt_cmd),
    .tgt_v_o     (tgt_v)
  );

  local_mem #(.MEM_WORDS_P(MEM_WORDS_P)) mem_i
  (
    .clk_i       (clk_i),
    .rst_i       (rst_r),
    .cmd_i       (tgt_cmd),
    .cmd_v_i     (tgt_v[e_tgt_mem]),
    .cmd_ready_o (tgt_ready[e_tgt_mem]),
    .resp_o      (tgt_resp[e_tgt_mem]),
    .resp_v_o    (tgt_resp_v[e_tgt_mem]),
    .resp_yumi_i (tgt_yumi[e_tgt_mem])
  );

  cfg_regs cfg_i
  (
    .clk_i       (clk_i),
    .rst_i       (rst_r),
    .cmd_i       (tgt_cmd),
    .cmd_v_i     (tgt_v[e_tgt_cfg]),
    .cmd_ready_o (tgt_ready[e_tgt_cfg]),
    .resp_o      (tgt_resp[e_tgt_cfg]),
    .resp_v_o    (tgt_resp_v[e_tgt_cfg]),
    .resp_yumi_i (tgt_yumi[e_tgt_cfg]),
    .cfg_o       (cfg_o)
  );

  clint_slice clint_i
  (
    .clk_i          (clk_i),
    .rst_i          (rst_r),
    .cmd_i          (tgt_cmd),
    .cmd_v_i        (tgt_v[e_tgt_clint]),
    .cmd_ready_o    (tgt_ready[e_tgt_clint]),
    .resp_o         (tgt_resp[e_tgt_clint]),
    .resp_v_o       (tgt_resp_v[e_tgt_clint]),
    .resp_yumi_i    (tgt_yumi[e_tgt_clint]),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o),
    .external_irq_o (external_irq_o)
  );

  resp_collect collect_i
  (
    .clk_i        (clk_i),
    .rst_i        (rst_r),
    .loop_cmd_i   (tgt_cmd),
    .loop_v_i     (tgt_v[e_tgt_loop]),
    .loop_ready_o (tgt_ready[e_tgt_loop]),
    .tgt_resp_i   (tgt_resp),
    .tgt_resp_v_i (tgt_resp_v),
    .tgt_yumi_o   (tgt_yumi),
    .resp_o       (resp_o),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i)
  );

endmodule

// ==== verilog/resp_collect.sv ====
/*
  Response side of the tile. Contains the loopback responder for unmapped
  local devices and merges the four response streams with fixed priority.
  Yumi goes back only to the granted source.
*/
`timescale 1ns/1ps

module resp_collect
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  tile_pkg::mem_cmd_s       loop_cmd_i,
  input  logic                     loop_v_i,
  output logic                     loop_ready_o,
  input  tile_pkg::mem_resp_s [2:0] tgt_resp_i,
  input  logic [2:0]               tgt_resp_v_i,
  output logic [2:0]               tgt_yumi_o,
  output tile_pkg::mem_resp_s      resp_o,
  output logic                     resp_v_o,
  input  logic                     resp_ready_i
);
  import tile_pkg::*;

  mem_resp_s       loop_resp_r;
  logic            loop_v_r;
  logic            loop_yumi;
  logic [3:0]      req;
  mem_resp_s [3:0] resp_all;
  tgt_e            sel;
  logic            take;

  // Loopback echoes opcode and address with zero data
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      loop_v_r <= 1'b0;
    end
    else if (loop_v_i)
    begin
      loop_v_r <= 1'b1;
    end
    else if (loop_yumi)
    begin
      loop_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (loop_v_i)
    begin
      loop_resp_r <= '{op: loop_cmd_i.op, addr: loop_cmd_i.addr, data: '0};
    end
  end

  assign loop_ready_o = ~loop_v_r;

  assign req      = {loop_v_r, tgt_resp_v_i};
  assign resp_all = {loop_resp_r, tgt_resp_i};

  // Lowest valid index wins
  always_comb
  begin
    sel = e_tgt_loop;
    for (int i = 2; i >= 0; i--)
    begin
      if (req[i])
      begin
        sel = tgt_e'(i);
      end
    end
  end

  assign resp_o   = resp_all[sel];
  assign resp_v_o = |req;
  assign take     = resp_v_o & resp_ready_i;

  assign tgt_yumi_o[e_tgt_mem]   = take & (sel == e_tgt_mem);
  assign tgt_yumi_o[e_tgt_cfg]   = take & (sel == e_tgt_cfg);
  assign tgt_yumi_o[e_tgt_clint] = take & (sel == e_tgt_clint);
  assign loop_yumi               = take & (sel == e_tgt_loop);

endmodule

// ==== verilog/tile_pkg.sv ====
/*
  Shared types and address map for the memory-side tile.
  Holds the command and response structs, the opcode, device and target
  enums, and the register offsets of the cfg and clint windows.
*/
package tile_pkg;

  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 64;
  localparam int DEV_LSB = 16;

  // Anything below this base is a local device access
  localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;

  typedef enum logic
  {
    e_op_rd,
    e_op_wr
  } mem_op_e;

  typedef enum logic [3:0]
  {
    e_dev_mem   = 4'd0,
    e_dev_clint = 4'd1,
    e_dev_cfg   = 4'd2
  } dev_e;

  // Index order doubles as response priority, lowest first
  typedef enum logic [1:0]
  {
    e_tgt_mem,
    e_tgt_cfg,
    e_tgt_clint,
    e_tgt_loop
  } tgt_e;

  typedef struct packed
  {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_cmd_s;

  typedef struct packed
  {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_resp_s;

  typedef struct packed
  {
    logic       freeze;
    logic [7:0] core_id;
  } cfg_s;

  // Clint window offsets
  localparam logic [15:0] CLINT_MSIP_OFS     = 16'h0000;
  localparam logic [15:0] CLINT_MTIMECMP_OFS = 16'h4000;
  localparam logic [15:0] CLINT_MEIP_OFS     = 16'h8000;
  localparam logic [15:0] CLINT_MTIME_OFS    = 16'hBFF8;

  // Cfg window offsets
  localparam logic [7:0] CFG_FREEZE_OFS  = 8'h00;
  localparam logic [7:0] CFG_CORE_ID_OFS = 8'h08;

endpackage
